//--- design/radio_pkg.sv
`default_nettype none

package radio_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int ADDR_W     = 20;
  localparam int DATA_W     = 32;
  localparam int TIME_W     = 64;
  localparam int SAMP_W     = 32;
  localparam int NSPC       = 2;
  localparam int RADIO_W    = SAMP_W * NSPC;
  localparam int PKT_LEN_W  = 16;
  localparam int CHAN_IDX_W = 4;

  // Major version in the upper half, minor in the lower half
  localparam logic [DATA_W-1:0] COMPAT_NUM = {16'd1, 16'd0};

  // ------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------
  localparam logic [6:0] BLOCK_SHARED = 7'd0;
  localparam logic [6:0] BLOCK_RADIO  = 7'd1;

  // Shared register offsets
  localparam logic [7:0] REG_COMPAT   = 8'h00;
  localparam logic [7:0] REG_NUM_CHAN = 8'h04;

  // Per-channel register offsets
  localparam logic [7:0] REG_RX_CTRL    = 8'h00;
  localparam logic [7:0] REG_RX_PKT_LEN = 8'h04;
  localparam logic [7:0] REG_STATUS     = 8'h08;

  // ------------------------------------------------------------
  // Control port
  // ------------------------------------------------------------
  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } ctrl_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] data;
  } ctrl_resp_t;

  // Internal register view of an address
  typedef struct packed {
    logic                  periph;
    logic [6:0]            block_sel;
    logic [CHAN_IDX_W-1:0] chan;
    logic [7:0]            offset;
  } radio_addr_t;

  // External peripheral window view of the same address
  typedef struct packed {
    logic        periph;
    logic [18:0] offset;
  } periph_addr_t;

  typedef union packed {
    radio_addr_t  radio;
    periph_addr_t window;
  } ctrl_addr_u;

  // ------------------------------------------------------------
  // Sample streams
  // ------------------------------------------------------------
  typedef struct packed {
    logic [RADIO_W-1:0] data;
    logic               last;
    logic [TIME_W-1:0]  timestamp;
  } rx_beat_t;

  typedef struct packed {
    logic [RADIO_W-1:0] data;
    logic               last;
  } tx_beat_t;

endpackage

`default_nettype wire

//--- design/tx_player.sv
`timescale 1ns/1ps
`default_nettype none

module tx_player (
  input  wire                             radio_clk,
  input  wire                             radio_rst,
  input  radio_pkg::tx_beat_t             tx_beat,
  input  wire                             tx_valid,
  output logic                            tx_ready,
  output logic [radio_pkg::RADIO_W-1:0]   radio_tx_data,
  input  wire                             radio_tx_stb,
  output logic                            radio_tx_running,
  output logic                            underrun
);

  // The radio pulls one beat per strobe
  assign tx_ready = radio_tx_stb;

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      radio_tx_data    <= '0;
      radio_tx_running <= 1'b0;
      underrun         <= 1'b0;
    end else begin
      underrun <= 1'b0;
      if (radio_tx_stb) begin
        if (tx_valid) begin
          radio_tx_data    <= tx_beat.data;
          // Burst ends on the strobe that plays the last beat
          radio_tx_running <= !tx_beat.last;
        end else begin
          // Starved strobe, send silence
          radio_tx_data <= '0;
          if (radio_tx_running) begin
            underrun <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/rx_packetizer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_packetizer (
  input  wire                               radio_clk,
  input  wire                               radio_rst,
  input  wire                               enable,
  input  wire  [radio_pkg::PKT_LEN_W-1:0]   pkt_len,
  input  wire  [radio_pkg::TIME_W-1:0]      radio_time,
  input  wire  [radio_pkg::RADIO_W-1:0]     radio_rx_data,
  input  wire                               radio_rx_stb,
  output radio_pkg::rx_beat_t               rx_beat,
  output logic                              rx_valid,
  input  wire                               rx_ready,
  output logic                              overflow
);

  import radio_pkg::*;

  logic [PKT_LEN_W-1:0] len_eff;
  logic [PKT_LEN_W-1:0] word_cnt;
  logic [TIME_W-1:0]    pkt_time;
  logic                 can_store;
  logic                 take;
  logic                 first;
  logic                 at_last;

  // A length of zero behaves as one beat per packet
  assign len_eff = (pkt_len == '0) ? PKT_LEN_W'(1) : pkt_len;

  // Output register is free if empty or draining this cycle
  assign can_store = !rx_valid || rx_ready;
  assign take      = enable && radio_rx_stb && can_store;
  assign first     = (word_cnt == '0);
  assign at_last   = (word_cnt == len_eff - 1'b1);

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      rx_valid <= 1'b0;
      word_cnt <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= enable && radio_rx_stb && !can_store;

      if (take) begin
        rx_valid <= 1'b1;
      end else if (rx_ready) begin
        rx_valid <= 1'b0;
      end

      if (!enable) begin
        word_cnt <= '0;
      end else if (take) begin
        word_cnt <= at_last ? '0 : word_cnt + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Beat payload
  // ------------------------------------------------------------
  always_ff @(posedge radio_clk) begin
    if (take) begin
      rx_beat.data      <= radio_rx_data;
      rx_beat.last      <= at_last;
      rx_beat.timestamp <= first ? radio_time : pkt_time;
      if (first) begin
        pkt_time <= radio_time;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/radio_channel_regs.sv
`timescale 1ns/1ps
`default_nettype none

module radio_channel_regs (
  input  wire                                radio_clk,
  input  wire                                radio_rst,
  input  radio_pkg::ctrl_req_t               req,
  output radio_pkg::ctrl_resp_t              resp,
  output logic                               rx_enable,
  output logic [radio_pkg::PKT_LEN_W-1:0]    pkt_len,
  input  wire                                rx_overflow,
  input  wire                                tx_underrun
);

  import radio_pkg::*;

  ctrl_addr_u addr_u;
  logic [7:0] offset;
  logic       sts_overflow;
  logic       sts_underrun;

  // Only the offset matters here, the router already picked the channel
  assign addr_u = req.addr;
  assign offset = addr_u.radio.offset;

  // ------------------------------------------------------------
  // Control and sticky status
  // ------------------------------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      rx_enable    <= 1'b0;
      pkt_len      <= PKT_LEN_W'(1);
      sts_overflow <= 1'b0;
      sts_underrun <= 1'b0;
    end else begin
      if (rx_overflow) begin
        sts_overflow <= 1'b1;
      end
      if (tx_underrun) begin
        sts_underrun <= 1'b1;
      end
      if (req.wr) begin
        case (offset)
          REG_RX_CTRL:    rx_enable <= req.data[0];
          REG_RX_PKT_LEN: pkt_len   <= req.data[PKT_LEN_W-1:0];
          REG_STATUS: begin
            // Clear has priority over a same-cycle event
            sts_overflow <= 1'b0;
            sts_underrun <= 1'b0;
          end
          default: ;
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // Ack and readback
  // ------------------------------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      resp <= '0;
    end else begin
      resp.ack  <= req.wr | req.rd;
      resp.data <= '0;
      if (req.rd) begin
        case (offset)
          REG_RX_CTRL:    resp.data <= {{(DATA_W-1){1'b0}}, rx_enable};
          REG_RX_PKT_LEN: resp.data <= DATA_W'(pkt_len);
          REG_STATUS:     resp.data <= {{(DATA_W-2){1'b0}}, sts_underrun, sts_overflow};
          default:        resp.data <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- design/radio_channel.sv
`timescale 1ns/1ps
`default_nettype none

module radio_channel (
  input  wire                             radio_clk,
  input  wire                             radio_rst,
  input  radio_pkg::ctrl_req_t            req,
  output radio_pkg::ctrl_resp_t           resp,
  input  wire  [radio_pkg::TIME_W-1:0]    radio_time,
  input  wire  [radio_pkg::RADIO_W-1:0]   radio_rx_data,
  input  wire                             radio_rx_stb,
  output logic                            radio_rx_running,
  output radio_pkg::rx_beat_t             rx_beat,
  output logic                            rx_valid,
  input  wire                             rx_ready,
  input  radio_pkg::tx_beat_t             tx_beat,
  input  wire                             tx_valid,
  output logic                            tx_ready,
  output logic [radio_pkg::RADIO_W-1:0]   radio_tx_data,
  input  wire                             radio_tx_stb,
  output logic                            radio_tx_running
);

  import radio_pkg::*;

  logic                 rx_enable;
  logic [PKT_LEN_W-1:0] pkt_len;
  logic                 rx_overflow;
  logic                 tx_underrun;

  assign radio_rx_running = rx_enable;

  radio_channel_regs regs_inst (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .req         (req),
    .resp        (resp),
    .rx_enable   (rx_enable),
    .pkt_len     (pkt_len),
    .rx_overflow (rx_overflow),
    .tx_underrun (tx_underrun)
  );

  rx_packetizer rx_inst (
    .radio_clk     (radio_clk),
    .radio_rst     (radio_rst),
    .enable        (rx_enable),
    .pkt_len       (pkt_len),
    .radio_time    (radio_time),
    .radio_rx_data (radio_rx_data),
    .radio_rx_stb  (radio_rx_stb),
    .rx_beat       (rx_beat),
    .rx_valid      (rx_valid),
    .rx_ready      (rx_ready),
    .overflow      (rx_overflow)
  );

  tx_player tx_inst (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .tx_beat          (tx_beat),
    .tx_valid         (tx_valid),
    .tx_ready         (tx_ready),
    .radio_tx_data    (radio_tx_data),
    .radio_tx_stb     (radio_tx_stb),
    .radio_tx_running (radio_tx_running),
    .underrun         (tx_underrun)
  );

endmodule

`default_nettype wire

//--- design/ctrl_port_router.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_port_router #(
  parameter int NUM_CHANNELS = 2
) (
  input  wire                                        radio_clk,
  input  wire                                        radio_rst,
  input  radio_pkg::ctrl_req_t                       ctrl_req,
  output radio_pkg::ctrl_resp_t                      ctrl_resp,
  output radio_pkg::ctrl_req_t  [NUM_CHANNELS-1:0]   chan_req,
  input  radio_pkg::ctrl_resp_t [NUM_CHANNELS-1:0]   chan_resp,
  output radio_pkg::ctrl_req_t                       periph_req,
  input  radio_pkg::ctrl_resp_t                      periph_resp
);

  import radio_pkg::*;

  ctrl_addr_u              addr_u;
  logic                    req_any;
  logic                    is_periph;
  logic                    shared_hit;
  logic                    chan_hit;
  logic [NUM_CHANNELS-1:0] chan_sel;

  // Responses owned by the router itself
  logic                    local_ack;
  logic [DATA_W-1:0]       local_data;
  logic [NUM_CHANNELS-1:0] chan_pend;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  assign addr_u     = ctrl_req.addr;
  assign req_any    = ctrl_req.wr | ctrl_req.rd;
  assign is_periph  = addr_u.window.periph;
  assign shared_hit = !is_periph && (addr_u.radio.block_sel == BLOCK_SHARED);
  assign chan_hit   = !is_periph && (addr_u.radio.block_sel == BLOCK_RADIO) &&
                      (int'(addr_u.radio.chan) < NUM_CHANNELS);

  // Peripheral window passes straight through
  always_comb begin
    periph_req    = ctrl_req;
    periph_req.wr = ctrl_req.wr & is_periph;
    periph_req.rd = ctrl_req.rd & is_periph;
  end

  // One strobe per channel, only for the addressed one
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan_req
    assign chan_sel[i] = chan_hit && (addr_u.radio.chan == CHAN_IDX_W'(i));

    always_comb begin
      chan_req[i]    = ctrl_req;
      chan_req[i].wr = ctrl_req.wr & chan_sel[i];
      chan_req[i].rd = ctrl_req.rd & chan_sel[i];
    end
  end

  // ------------------------------------------------------------
  // Shared registers and unmapped requests
  // ------------------------------------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      local_ack  <= 1'b0;
      local_data <= '0;
      chan_pend  <= '0;
    end else begin
      local_ack  <= req_any && !is_periph && !chan_hit;
      local_data <= '0;
      chan_pend  <= chan_sel & {NUM_CHANNELS{req_any}};
      // Shared space is read-only, writes just get acked
      if (ctrl_req.rd && shared_hit) begin
        case (addr_u.radio.offset)
          REG_COMPAT:   local_data <= COMPAT_NUM;
          REG_NUM_CHAN: local_data <= DATA_W'(NUM_CHANNELS);
          default:      local_data <= '0;
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // Response merge
  // ------------------------------------------------------------
  always_comb begin
    ctrl_resp = '0;
    if (local_ack) begin
      ctrl_resp.ack  = 1'b1;
      ctrl_resp.data = local_data;
    end
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (chan_pend[i]) begin
        ctrl_resp = chan_resp[i];
      end
    end
    // Peripheral latency is unknown, so its ack is taken whenever it comes
    if (periph_resp.ack) begin
      ctrl_resp = periph_resp;
    end
  end

endmodule

`default_nettype wire

//--- design/radio_block.sv
`timescale 1ns/1ps
`default_nettype none

module radio_block #(
  parameter int NUM_CHANNELS = 2
) (
  input  wire                                               radio_clk,
  input  wire                                               radio_rst,
  input  radio_pkg::ctrl_req_t                              ctrl_req,
  output radio_pkg::ctrl_resp_t                             ctrl_resp,
  output radio_pkg::ctrl_req_t                              periph_req,
  input  radio_pkg::ctrl_resp_t                             periph_resp,
  input  wire  [radio_pkg::TIME_W-1:0]                      radio_time,
  input  wire  [NUM_CHANNELS-1:0][radio_pkg::RADIO_W-1:0]   radio_rx_data,
  input  wire  [NUM_CHANNELS-1:0]                           radio_rx_stb,
  output logic [NUM_CHANNELS-1:0]                           radio_rx_running,
  output radio_pkg::rx_beat_t [NUM_CHANNELS-1:0]            rx_beat,
  output logic [NUM_CHANNELS-1:0]                           rx_valid,
  input  wire  [NUM_CHANNELS-1:0]                           rx_ready,
  input  radio_pkg::tx_beat_t [NUM_CHANNELS-1:0]            tx_beat,
  input  wire  [NUM_CHANNELS-1:0]                           tx_valid,
  output logic [NUM_CHANNELS-1:0]                           tx_ready,
  output logic [NUM_CHANNELS-1:0][radio_pkg::RADIO_W-1:0]   radio_tx_data,
  input  wire  [NUM_CHANNELS-1:0]                           radio_tx_stb,
  output logic [NUM_CHANNELS-1:0]                           radio_tx_running
);

  import radio_pkg::*;

  ctrl_req_t  [NUM_CHANNELS-1:0] chan_req;
  ctrl_resp_t [NUM_CHANNELS-1:0] chan_resp;

  // ------------------------------------------------------------
  // Control port split and merge
  // ------------------------------------------------------------
  ctrl_port_router #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) router_inst (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .ctrl_req    (ctrl_req),
    .ctrl_resp   (ctrl_resp),
    .chan_req    (chan_req),
    .chan_resp   (chan_resp),
    .periph_req  (periph_req),
    .periph_resp (periph_resp)
  );

  // ------------------------------------------------------------
  // Channels
  // ------------------------------------------------------------
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    radio_channel chan_inst (
      .radio_clk        (radio_clk),
      .radio_rst        (radio_rst),
      .req              (chan_req[i]),
      .resp             (chan_resp[i]),
      .radio_time       (radio_time),
      .radio_rx_data    (radio_rx_data[i]),
      .radio_rx_stb     (radio_rx_stb[i]),
      .radio_rx_running (radio_rx_running[i]),
      .rx_beat          (rx_beat[i]),
      .rx_valid         (rx_valid[i]),
      .rx_ready         (rx_ready[i]),
      .tx_beat          (tx_beat[i]),
      .tx_valid         (tx_valid[i]),
      .tx_ready         (tx_ready[i]),
      .radio_tx_data    (radio_tx_data[i]),
      .radio_tx_stb     (radio_tx_stb[i]),
      .radio_tx_running (radio_tx_running[i])
    );
  end

endmodule

`default_nettype wire

//--- testbench/radio_block_tb.sv
`timescale 1ns/1ps
`default_nettype none

module radio_block_tb;

  import radio_pkg::*;

  localparam int NUM_CH     = 2;
  localparam int RX_PKT_LEN = 4;
  // Far above the few hundred cycles of the sequence
  localparam int MAX_CYCLES = 5000;

  logic                             radio_clk;
  logic                             radio_rst;
  ctrl_req_t                        ctrl_req;
  ctrl_resp_t                       ctrl_resp;
  ctrl_req_t                        periph_req;
  ctrl_resp_t                       periph_resp = '0;
  logic [TIME_W-1:0]                radio_time = '0;
  logic [NUM_CH-1:0][RADIO_W-1:0]   radio_rx_data;
  logic [NUM_CH-1:0]                radio_rx_stb;
  logic [NUM_CH-1:0]                radio_rx_running;
  rx_beat_t [NUM_CH-1:0]            rx_beat;
  logic [NUM_CH-1:0]                rx_valid;
  logic [NUM_CH-1:0]                rx_ready;
  tx_beat_t [NUM_CH-1:0]            tx_beat;
  logic [NUM_CH-1:0]                tx_valid;
  logic [NUM_CH-1:0]                tx_ready;
  logic [NUM_CH-1:0][RADIO_W-1:0]   radio_tx_data;
  logic [NUM_CH-1:0]                radio_tx_stb;
  logic [NUM_CH-1:0]                radio_tx_running;

  integer            seed = 32'he5ce_0349;
  int                cycles = 0;
  logic [NUM_CH-1:0] rx_en_model;
  logic              rx_expect_keep;
  rx_beat_t          rx_exp_q[$];
  rx_beat_t          rx_head;
  logic              rx_head_valid;
  int                rx_word;
  logic [TIME_W-1:0] rx_pkt_time;

  // Peripheral model pipeline
  periph_addr_t      pm_addr;
  logic              pm_stage1;
  logic              pm_stage2;
  logic [18:0]       pm_off1;
  logic [18:0]       pm_off2;

  logic              int_req;
  logic              per_req;
  logic              rx_xfer;
  logic              tx_play;
  logic              tx_starve;

  radio_block #(
    .NUM_CHANNELS (NUM_CH)
  ) radio_block_inst (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .ctrl_req         (ctrl_req),
    .ctrl_resp        (ctrl_resp),
    .periph_req       (periph_req),
    .periph_resp      (periph_resp),
    .radio_time       (radio_time),
    .radio_rx_data    (radio_rx_data),
    .radio_rx_stb     (radio_rx_stb),
    .radio_rx_running (radio_rx_running),
    .rx_beat          (rx_beat),
    .rx_valid         (rx_valid),
    .rx_ready         (rx_ready),
    .tx_beat          (tx_beat),
    .tx_valid         (tx_valid),
    .tx_ready         (tx_ready),
    .radio_tx_data    (radio_tx_data),
    .radio_tx_stb     (radio_tx_stb),
    .radio_tx_running (radio_tx_running)
  );

  initial radio_clk = 1'b0;
  always #50 radio_clk = ~radio_clk;

  always @(negedge radio_clk) begin
    radio_time <= radio_time + 64'd1;
  end

  always @(posedge radio_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic report_failure(input string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  // ------------------------------------------------------------
  // Peripheral model acking two cycles after the request
  // ------------------------------------------------------------
  assign pm_addr = periph_req.addr;

  always @(posedge radio_clk) begin
    if (radio_rst) begin
      pm_stage1 <= 1'b0;
      pm_stage2 <= 1'b0;
    end else begin
      pm_stage1 <= periph_req.wr | periph_req.rd;
      pm_stage2 <= pm_stage1;
    end
    pm_off1 <= pm_addr.offset;
    pm_off2 <= pm_off1;
  end

  always @(negedge radio_clk) begin
    periph_resp.ack  <= pm_stage2;
    periph_resp.data <= pm_stage2 ? DATA_W'(pm_off2) + 32'h100 : '0;
  end

  // ------------------------------------------------------------
  // Expected rx beats filled from the strobed samples
  // ------------------------------------------------------------
  assign rx_xfer = rx_valid[0] && rx_ready[0];

  always @(posedge radio_clk) begin
    rx_beat_t exp_beat;
    if (radio_rst) begin
      rx_word       = 0;
      rx_head_valid = 1'b0;
    end else begin
      if (rx_xfer && rx_exp_q.size() > 0) begin
        void'(rx_exp_q.pop_front());
      end
      if (radio_rx_stb[0] && rx_expect_keep) begin
        // Timestamp of a packet is the time of its first sample
        if (rx_word == 0) begin
          rx_pkt_time = radio_time;
        end
        exp_beat.data      = radio_rx_data[0];
        exp_beat.last      = (rx_word == RX_PKT_LEN - 1);
        exp_beat.timestamp = rx_pkt_time;
        rx_exp_q.push_back(exp_beat);
        rx_word = (rx_word + 1) % RX_PKT_LEN;
      end
      rx_head_valid = (rx_exp_q.size() > 0);
      if (rx_head_valid) begin
        rx_head = rx_exp_q[0];
      end
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  assign int_req   = (ctrl_req.wr || ctrl_req.rd) && !ctrl_req.addr[ADDR_W-1];
  assign per_req   = (ctrl_req.wr || ctrl_req.rd) && ctrl_req.addr[ADDR_W-1];
  assign tx_play   = radio_tx_stb[0] && tx_valid[0];
  assign tx_starve = radio_tx_stb[0] && !tx_valid[0];

  a_int_ack: assert property (@(posedge radio_clk) disable iff (radio_rst)
    int_req |=> ctrl_resp.ack)
    else report_failure("internal request not acked one cycle later");

  a_periph_fwd: assert property (@(posedge radio_clk) disable iff (radio_rst)
    per_req |-> periph_req == ctrl_req)
    else report_failure("peripheral request differs from the control request");

  a_periph_quiet: assert property (@(posedge radio_clk) disable iff (radio_rst)
    !per_req |-> !(periph_req.wr || periph_req.rd))
    else report_failure("peripheral strobe without a peripheral address");

  a_rx_running: assert property (@(posedge radio_clk) disable iff (radio_rst)
    radio_rx_running == rx_en_model)
    else report_failure("radio_rx_running does not follow rx enable");

  a_rx_expected: assert property (@(posedge radio_clk) disable iff (radio_rst)
    rx_xfer |-> rx_head_valid)
    else report_failure("rx beat transferred with no sample expected");

  a_rx_data: assert property (@(posedge radio_clk) disable iff (radio_rst)
    rx_xfer |-> rx_beat[0].data == rx_head.data)
    else report_failure("rx beat data out of order or wrong");

  a_rx_last: assert property (@(posedge radio_clk) disable iff (radio_rst)
    rx_xfer |-> rx_beat[0].last == rx_head.last)
    else report_failure("rx last flag at the wrong beat");

  a_rx_time: assert property (@(posedge radio_clk) disable iff (radio_rst)
    rx_xfer |-> rx_beat[0].timestamp == rx_head.timestamp)
    else report_failure("rx timestamp differs from the first sample time");

  a_tx_ready: assert property (@(posedge radio_clk) disable iff (radio_rst)
    tx_ready == radio_tx_stb)
    else report_failure("tx_ready does not follow the tx strobe");

  a_tx_data: assert property (@(posedge radio_clk) disable iff (radio_rst)
    tx_play |=> radio_tx_data[0] == $past(tx_beat[0].data))
    else report_failure("tx beat not played on the radio");

  a_tx_run: assert property (@(posedge radio_clk) disable iff (radio_rst)
    tx_play && !tx_beat[0].last |=> radio_tx_running[0])
    else report_failure("tx not running inside a burst");

  a_tx_stop: assert property (@(posedge radio_clk) disable iff (radio_rst)
    tx_play && tx_beat[0].last |=> !radio_tx_running[0])
    else report_failure("tx still running after the last beat");

  a_tx_silence: assert property (@(posedge radio_clk) disable iff (radio_rst)
    tx_starve && radio_tx_running[0] |=> radio_tx_data[0] == '0)
    else report_failure("starved tx strobe did not send zero");

  // Channel 1 never sees a strobe
  a_ch1_idle: assert property (@(posedge radio_clk) disable iff (radio_rst)
    !rx_valid[1] && !radio_tx_running[1] && radio_tx_data[1] == '0)
    else report_failure("channel 1 moved without any channel 1 stimulus");

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  function automatic logic [ADDR_W-1:0] reg_addr(input logic [6:0] blk, input int chan,
                                                 input logic [7:0] off);
    radio_addr_t a;
    a.periph    = 1'b0;
    a.block_sel = blk;
    a.chan      = chan[CHAN_IDX_W-1:0];
    a.offset    = off;
    return a;
  endfunction

  function automatic logic [ADDR_W-1:0] periph_addr(input logic [18:0] off);
    periph_addr_t a;
    a.periph = 1'b1;
    a.offset = off;
    return a;
  endfunction

  task automatic ctrl_access(input logic is_wr, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    radio_addr_t ra;
    ra = addr;
    @(negedge radio_clk);
    ctrl_req.wr   = is_wr;
    ctrl_req.rd   = !is_wr;
    ctrl_req.addr = addr;
    ctrl_req.data = is_wr ? wdata : '0;
    @(posedge radio_clk);
    // Rx enable changes at the request edge
    if (is_wr && !ra.periph && ra.block_sel == BLOCK_RADIO && ra.offset == REG_RX_CTRL &&
        int'(ra.chan) < NUM_CH) begin
      rx_en_model[ra.chan[0]] = wdata[0];
    end
    @(negedge radio_clk);
    ctrl_req = '0;
    @(posedge radio_clk);
    while (!ctrl_resp.ack) begin
      @(posedge radio_clk);
    end
    rdata = ctrl_resp.data;
  endtask

  task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] ignored;
    ctrl_access(1'b1, addr, data, ignored);
  endtask

  task automatic read_check(input string what, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] got;
    ctrl_access(1'b0, addr, '0, got);
    assert (got == exp)
      else report_failure($sformatf("%s read 0x%0h, expected 0x%0h", what, got, exp));
  endtask

  task automatic rx_strobe(input logic keep);
    @(negedge radio_clk);
    radio_rx_data[0] = {$random(seed), $random(seed)};
    radio_rx_stb[0]  = 1'b1;
    rx_expect_keep   = keep;
    @(negedge radio_clk);
    radio_rx_stb[0]  = 1'b0;
    rx_expect_keep   = 1'b0;
  endtask

  task automatic wait_rx_drain();
    while (rx_exp_q.size() != 0 || rx_valid[0]) begin
      @(posedge radio_clk);
    end
  endtask

  task automatic tx_strobe(input logic valid, input logic last);
    @(negedge radio_clk);
    radio_tx_stb[0]  = 1'b1;
    tx_valid[0]      = valid;
    tx_beat[0].data  = valid ? {$random(seed), $random(seed)} : '0;
    tx_beat[0].last  = last;
  endtask

  task automatic tx_idle();
    @(negedge radio_clk);
    radio_tx_stb[0] = 1'b0;
    tx_valid[0]     = 1'b0;
    tx_beat[0]      = '0;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    ctrl_req       = '0;
    radio_rx_data  = '0;
    radio_rx_stb   = '0;
    rx_ready       = '1;
    tx_beat        = '0;
    tx_valid       = '0;
    radio_tx_stb   = '0;
    rx_en_model    = '0;
    rx_expect_keep = 1'b0;
    radio_rst      = 1'b1;
    repeat (3) @(posedge radio_clk);
    @(negedge radio_clk);
    radio_rst = 1'b0;

    // Shared space, unmapped offsets and a missing channel
    read_check("compat", reg_addr(BLOCK_SHARED, 0, REG_COMPAT), 32'h0001_0000);
    read_check("num_chan", reg_addr(BLOCK_SHARED, 0, REG_NUM_CHAN), DATA_W'(NUM_CH));
    reg_write(reg_addr(BLOCK_SHARED, 0, REG_COMPAT), 32'hffff_ffff);
    read_check("compat after write", reg_addr(BLOCK_SHARED, 0, REG_COMPAT), 32'h0001_0000);
    read_check("unmapped shared", reg_addr(BLOCK_SHARED, 0, 8'h40), '0);
    read_check("channel 3", reg_addr(BLOCK_RADIO, 3, REG_RX_PKT_LEN), '0);

    // Channel isolation
    read_check("ch0 pkt_len reset", reg_addr(BLOCK_RADIO, 0, REG_RX_PKT_LEN), 32'd1);
    reg_write(reg_addr(BLOCK_RADIO, 0, REG_RX_PKT_LEN), DATA_W'(RX_PKT_LEN));
    reg_write(reg_addr(BLOCK_RADIO, 1, REG_RX_PKT_LEN), 32'd7);
    read_check("ch0 pkt_len", reg_addr(BLOCK_RADIO, 0, REG_RX_PKT_LEN), DATA_W'(RX_PKT_LEN));
    read_check("ch1 pkt_len", reg_addr(BLOCK_RADIO, 1, REG_RX_PKT_LEN), 32'd7);

    // Peripheral window
    reg_write(periph_addr(19'h0_0123), 32'hcafe_0001);
    read_check("peripheral", periph_addr(19'h4_5678), 32'h0004_5778);

    // Two full rx packets
    reg_write(reg_addr(BLOCK_RADIO, 0, REG_RX_CTRL), 32'd1);
    repeat (2 * RX_PKT_LEN) rx_strobe(1'b1);
    wait_rx_drain();

    // The second sample finds the output register full and overflows
    @(negedge radio_clk);
    rx_ready[0] = 1'b0;
    rx_strobe(1'b1);
    rx_strobe(1'b0);
    read_check("ch0 status overflow", reg_addr(BLOCK_RADIO, 0, REG_STATUS), 32'h1);
    reg_write(reg_addr(BLOCK_RADIO, 0, REG_STATUS), 32'h0);
    read_check("ch0 status cleared", reg_addr(BLOCK_RADIO, 0, REG_STATUS), 32'h0);
    @(negedge radio_clk);
    rx_ready[0] = 1'b1;
    repeat (RX_PKT_LEN - 1) rx_strobe(1'b1);
    wait_rx_drain();
    reg_write(reg_addr(BLOCK_RADIO, 0, REG_RX_CTRL), 32'd0);

    // Clean tx burst followed by a starved strobe outside any burst
    tx_strobe(1'b1, 1'b0);
    tx_strobe(1'b1, 1'b0);
    tx_strobe(1'b1, 1'b1);
    tx_strobe(1'b0, 1'b0);
    tx_idle();
    read_check("ch0 status after burst", reg_addr(BLOCK_RADIO, 0, REG_STATUS), 32'h0);

    // Burst with a starved strobe in the middle
    tx_strobe(1'b1, 1'b0);
    tx_strobe(1'b0, 1'b0);
    tx_strobe(1'b1, 1'b1);
    tx_idle();
    read_check("ch0 status underrun", reg_addr(BLOCK_RADIO, 0, REG_STATUS), 32'h2);

    repeat (2) @(posedge radio_clk);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/radio_pkg.sv
design/tx_player.sv
design/rx_packetizer.sv
design/radio_channel_regs.sv
design/radio_channel.sv
design/ctrl_port_router.sv
design/radio_block.sv
testbench/radio_block_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := radio_block_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
